/* sim.f */
+incdir+rtl
rtl/interp_ctrl_pkg.sv
rtl/interp_data_pkg.sv
rtl/booth_multiplier.sv
rtl/restoring_divider.sv
rtl/interp_datapath.sv
rtl/interp_fsm.sv
rtl/interp_unit.sv
verif/interp_clock_gen.sv
verif/interp_table_ram.sv
verif/tb_interp_unit.sv

/* verif/tb_interp_unit.sv */
`timescale 1ns/1ps
`include "interp_settings.svh"

module tb_interp_unit;

    localparam int WAIT_LIMIT = 400;
    localparam int WORD_MAX = (1 << (`INTERP_WORD_W - 1)) - 1;
    localparam int WORD_MIN = -(1 << (`INTERP_WORD_W - 1));

    logic clk;
    logic reset;
    logic cmd_valid;
    interp_ctrl_pkg::opcode_e cmd_op;
    interp_data_pkg::word_t cmd_tk;
    interp_data_pkg::addr_t cmd_dest;
    logic cmd_ready;
    logic res_valid;
    interp_data_pkg::word_t res_value;
    logic res_overflow;
    logic res_ready;
    interp_data_pkg::addr_t ram_addr1;
    interp_data_pkg::addr_t ram_addr2;
    interp_data_pkg::word_t ram_data1;
    interp_data_pkg::word_t ram_data2;
    interp_data_pkg::word_t ram_wdata;
    logic ram_we;

    integer seed = 32'h19a6;
    int value_errors = 0;
    int protocol_errors = 0;
    int timeout_errors = 0;
    int we_total = 0;
    string test_name = "reset";
    interp_data_pkg::word_t exp_value = '0;
    logic exp_ovf = 1'b0;
    logic exp_store = 1'b0;
    interp_data_pkg::addr_t exp_dest = '0;
    int tbl_n;
    int tbl_t [16];
    int tbl_u [16];

    interp_clock_gen u_clk (
        .clk(clk)
    );

    interp_unit u_dut (
        .clk(clk), .reset(reset),
        .cmd_valid(cmd_valid), .cmd_op(cmd_op), .cmd_tk(cmd_tk), .cmd_dest(cmd_dest),
        .cmd_ready(cmd_ready),
        .res_valid(res_valid), .res_value(res_value), .res_overflow(res_overflow),
        .res_ready(res_ready),
        .ram_addr1(ram_addr1), .ram_addr2(ram_addr2),
        .ram_data1(ram_data1), .ram_data2(ram_data2),
        .ram_we(ram_we), .ram_wdata(ram_wdata)
    );

    interp_table_ram u_ram (
        .clk(clk),
        .addr1(ram_addr1), .data1(ram_data1),
        .addr2(ram_addr2), .data2(ram_data2),
        .we(ram_we), .wdata(ram_wdata)
    );

    a_value: assert property (@(posedge clk) disable iff (reset)
        res_valid |-> res_value == exp_value)
        else begin
            value_errors++;
            $display("FAIL %s expected %0d actual %0d", test_name, exp_value,
                     $sampled(res_value));
        end

    a_overflow: assert property (@(posedge clk) disable iff (reset)
        res_valid |-> res_overflow == exp_ovf)
        else begin
            value_errors++;
            $display("FAIL %s_overflow expected %0d actual %0d", test_name, exp_ovf,
                     $sampled(res_overflow));
        end

    a_we_store_only: assert property (@(posedge clk) disable iff (reset)
        ram_we |-> exp_store)
        else begin
            protocol_errors++;
            $display("ram_we pulsed for a command without store in %s", test_name);
        end

    a_we_addr: assert property (@(posedge clk) disable iff (reset)
        ram_we |-> ram_addr2 == exp_dest)
        else begin
            value_errors++;
            $display("FAIL %s_addr expected %h actual %h", test_name, exp_dest,
                     $sampled(ram_addr2));
        end

    a_we_data: assert property (@(posedge clk) disable iff (reset)
        ram_we |-> ram_wdata == exp_value)
        else begin
            value_errors++;
            $display("FAIL %s_wdata expected %0d actual %0d", test_name, exp_value,
                     $sampled(ram_wdata));
        end

    a_we_pulse: assert property (@(posedge clk) disable iff (reset)
        ram_we |=> !ram_we)
        else begin
            protocol_errors++;
            $display("ram_we stayed high for more than one cycle in %s", test_name);
        end

    a_hold: assert property (@(posedge clk) disable iff (reset)
        res_valid && !res_ready |=> res_valid && $stable(res_value) && $stable(res_overflow))
        else begin
            protocol_errors++;
            $display("result dropped or changed under back-pressure in %s", test_name);
        end

    a_no_cmd: assert property (@(posedge clk) disable iff (reset)
        res_valid |-> !cmd_ready)
        else begin
            protocol_errors++;
            $display("command channel ready while a result is pending in %s", test_name);
        end

    // sampled mid-cycle, away from the edge
    always @(negedge clk) begin
        if (ram_we) begin
            we_total++;
        end
    end

    function automatic int wrap_word(input int v);
        interp_data_pkg::word_t w;
        w = v[`INTERP_WORD_W-1:0];
        return w;
    endfunction

    function automatic int rand_below(input int n);
        return $unsigned($random(seed)) % n;
    endfunction

    task automatic set_count(input int n);
        tbl_n = n;
        u_ram.mem[`INTERP_COUNT_ADDR] = n[`INTERP_WORD_W-1:0];
    endtask

    task automatic set_point(input int i, input int t, input int u);
        tbl_t[i] = t;
        tbl_u[i] = u;
        u_ram.mem[`INTERP_T_BASE + i] = t[`INTERP_WORD_W-1:0];
        u_ram.mem[`INTERP_U_BASE + i] = u[`INTERP_WORD_W-1:0];
    endtask

    task automatic model_interp(input int tk, output int value, output logic ovf);
        int i;
        int frac;
        int scaled;
        int sum;
        ovf = 1'b0;
        if (tk < tbl_t[0]) begin
            value = tbl_u[0];
        end else if (tk >= tbl_t[tbl_n-1]) begin
            value = tbl_u[tbl_n-1];
        end else begin
            i = 1;
            while (tk >= tbl_t[i]) begin
                i++;
            end
            frac = ((tk - tbl_t[i-1]) << `INTERP_FRAC) / (tbl_t[i] - tbl_t[i-1]);
            // u difference wraps to a word before the multiply
            scaled = (frac * wrap_word(tbl_u[i] - tbl_u[i-1])) >>> `INTERP_FRAC;
            sum = tbl_u[i-1] + wrap_word(scaled);
            ovf = scaled > WORD_MAX || scaled < WORD_MIN || sum > WORD_MAX || sum < WORD_MIN;
            value = wrap_word(sum);
        end
    endtask

    task automatic run_query(input string name, input interp_ctrl_pkg::opcode_e op,
                             input int tk, input int hold);
        int cycles;
        int value;
        int writes_before;
        logic ovf;
        interp_data_pkg::addr_t dest;
        if (timeout_errors != 0) begin
            return;
        end
        model_interp(tk, value, ovf);
        // destinations stay clear of the table
        dest = interp_data_pkg::addr_t'(16'h0400 + rand_below(256));
        test_name = name;
        exp_value = interp_data_pkg::word_t'(value);
        exp_ovf = ovf;
        exp_store = (op == interp_ctrl_pkg::OP_INTERP_STORE);
        exp_dest = dest;
        writes_before = we_total;
        cmd_valid = 1'b1;
        cmd_op = op;
        cmd_tk = interp_data_pkg::word_t'(tk);
        cmd_dest = dest;
        cycles = 0;
        while (!cmd_ready && cycles < WAIT_LIMIT) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (!cmd_ready) begin
            timeout_errors++;
            $display("timeout: command never accepted in %s", name);
            cmd_valid = 1'b0;
            return;
        end
        @(posedge clk);
        #1;
        cmd_valid = 1'b0;
        cycles = 0;
        while (!res_valid && cycles < WAIT_LIMIT) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (!res_valid) begin
            timeout_errors++;
            $display("timeout: no result returned in %s", name);
            return;
        end
        repeat (hold) begin
            @(posedge clk);
            #1;
        end
        res_ready = 1'b1;
        @(posedge clk);
        #1;
        res_ready = 1'b0;
        assert (we_total - writes_before == (exp_store ? 1 : 0))
            else begin
                protocol_errors++;
                $display("FAIL %s_writes expected %0d actual %0d", name,
                         exp_store ? 1 : 0, we_total - writes_before);
            end
        if (exp_store) begin
            assert (u_ram.mem[dest] == exp_value)
                else begin
                    value_errors++;
                    $display("FAIL %s_stored expected %0d actual %0d", name, exp_value,
                             u_ram.mem[dest]);
                end
        end
    endtask

    task automatic run_random_queries(input int count);
        int span;
        span = tbl_t[tbl_n-1] - tbl_t[0];
        for (int k = 0; k < count; k++) begin
            run_query("random", interp_ctrl_pkg::opcode_e'(rand_below(2)),
                      tbl_t[0] - 200 + rand_below(span + 400), rand_below(3));
        end
    endtask

    task automatic load_random_table();
        int n;
        int t;
        n = 4 + rand_below(8);
        t = -2000 + rand_below(500);
        set_count(n);
        for (int i = 0; i < n; i++) begin
            set_point(i, t, rand_below(8001) - 4000);
            t = t + 1 + rand_below(400);
        end
    endtask

    initial begin
        reset = 1'b1;
        cmd_valid = 1'b0;
        cmd_op = interp_ctrl_pkg::OP_INTERP;
        cmd_tk = '0;
        cmd_dest = '0;
        res_ready = 1'b0;
        repeat (8) @(posedge clk);
        #1;
        reset = 1'b0;
        assert (cmd_ready && !res_valid && !ram_we && !u_dut.div_start && !u_dut.mul_start)
            else begin
                protocol_errors++;
                $display("outputs not in their idle state after reset");
            end

        // t from -2.0 to 10.0, with a flat segment
        set_count(5);
        set_point(0, -256, 384);
        set_point(1, 0, -128);
        set_point(2, 192, 320);
        set_point(3, 512, 320);
        set_point(4, 1280, 2560);
        run_query("middle_seg", interp_ctrl_pkg::OP_INTERP, 352, 0);
        run_query("first_seg", interp_ctrl_pkg::OP_INTERP, -100, 0);
        run_query("at_first_t", interp_ctrl_pkg::OP_INTERP, -256, 0);
        run_query("last_seg", interp_ctrl_pkg::OP_INTERP, 1001, 0);
        run_query("below_first", interp_ctrl_pkg::OP_INTERP, -1000, 0);
        run_query("at_last_t", interp_ctrl_pkg::OP_INTERP, 1280, 0);
        run_query("above_last", interp_ctrl_pkg::OP_INTERP, 5000, 0);
        run_query("store_mid", interp_ctrl_pkg::OP_INTERP_STORE, 900, 0);
        run_query("store_clamp", interp_ctrl_pkg::OP_INTERP_STORE, -5000, 0);
        run_query("backpressure", interp_ctrl_pkg::OP_INTERP, 700, 6);
        run_query("backpressure_store", interp_ctrl_pkg::OP_INTERP_STORE, 100, 3);

        // u difference of the first segment wraps, so the sum overflows
        set_count(3);
        set_point(0, 0, -30000);
        set_point(1, 128, 30000);
        set_point(2, 256, 0);
        run_query("overflow_sum", interp_ctrl_pkg::OP_INTERP, 127, 0);
        run_query("overflow_sum_mid", interp_ctrl_pkg::OP_INTERP, 100, 2);
        run_query("steep_no_overflow", interp_ctrl_pkg::OP_INTERP, 200, 0);

        load_random_table();
        run_random_queries(30);

        $display("errors: value %0d protocol %0d timeout %0d",
                 value_errors, protocol_errors, timeout_errors);
        if (value_errors + protocol_errors + timeout_errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* verif/interp_table_ram.sv */
`timescale 1ns/1ps
`include "interp_settings.svh"

module interp_table_ram (
    input  logic                   clk,
    input  interp_data_pkg::addr_t addr1,
    output interp_data_pkg::word_t data1,
    input  interp_data_pkg::addr_t addr2,
    output interp_data_pkg::word_t data2,
    input  logic                   we,
    input  interp_data_pkg::word_t wdata
);

    interp_data_pkg::word_t mem [0:(1 << `INTERP_ADDR_W)-1];

    // background pattern built from every address bit
    initial begin
        for (int i = 0; i < (1 << `INTERP_ADDR_W); i++) begin
            mem[i] = interp_data_pkg::word_t'(i ^ (i >> 7) ^ 16'h5a5a);
        end
    end

    // reads return the old word on a same-address write
    always @(posedge clk) begin
        data1 <= mem[addr1];
        data2 <= mem[addr2];
        if (we) begin
            mem[addr2] <= wdata;
        end
    end

endmodule

/* verif/interp_clock_gen.sv */
`timescale 1ns/1ps

module interp_clock_gen (
    output logic clk
);

    // 20 ns period
    initial begin
        clk = 1'b0;
    end

    always begin
        #10 clk = ~clk;
    end

endmodule

/* rtl/interp_unit.sv */
`timescale 1ns/1ps
`include "interp_settings.svh"

module interp_unit (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     cmd_valid,
    input  interp_ctrl_pkg::opcode_e cmd_op,
    input  interp_data_pkg::word_t   cmd_tk,
    input  interp_data_pkg::addr_t   cmd_dest,
    output logic                     cmd_ready,
    output logic                     res_valid,
    output interp_data_pkg::word_t   res_value,
    output logic                     res_overflow,
    input  logic                     res_ready,
    output interp_data_pkg::addr_t   ram_addr1,
    output interp_data_pkg::addr_t   ram_addr2,
    input  interp_data_pkg::word_t   ram_data1,
    input  interp_data_pkg::word_t   ram_data2,
    output logic                     ram_we,
    output interp_data_pkg::word_t   ram_wdata
);

    logic load_count, load_lo, load_hi, advance, load_frac, load_result;
    logic addr_sel, res_sel;
    logic tk_below_first, tk_in_segment, at_last_segment;
    logic div_start, div_done, mul_start, mul_done;
    logic [`INTERP_WORD_W+`INTERP_FRAC-1:0] div_dividend;
    interp_data_pkg::word_t div_divisor, div_quotient;
    interp_data_pkg::word_t mul_a, mul_b;
    interp_data_pkg::prod_t mul_product;

    interp_fsm u_fsm (
        .clk(clk), .reset(reset),
        .cmd_valid(cmd_valid), .cmd_op(cmd_op), .res_ready(res_ready),
        .tk_below_first(tk_below_first), .tk_in_segment(tk_in_segment),
        .at_last_segment(at_last_segment),
        .div_done(div_done), .mul_done(mul_done),
        .cmd_ready(cmd_ready), .res_valid(res_valid), .ram_we(ram_we),
        .load_count(load_count), .load_lo(load_lo), .load_hi(load_hi),
        .advance(advance), .load_frac(load_frac), .load_result(load_result),
        .addr_sel(addr_sel), .res_sel(res_sel),
        .div_start(div_start), .mul_start(mul_start)
    );

    // query registers track the command port while idle
    interp_datapath u_datapath (
        .clk(clk), .reset(reset),
        .cmd_tk(cmd_tk), .cmd_dest(cmd_dest), .load_cmd(cmd_ready),
        .load_count(load_count), .load_lo(load_lo), .load_hi(load_hi),
        .advance(advance), .load_frac(load_frac), .load_result(load_result),
        .addr_sel(addr_sel), .res_sel(res_sel),
        .ram_data1(ram_data1), .ram_data2(ram_data2),
        .div_quotient(div_quotient), .mul_product(mul_product),
        .ram_addr1(ram_addr1), .ram_addr2(ram_addr2), .ram_wdata(ram_wdata),
        .res_value(res_value), .res_overflow(res_overflow),
        .div_dividend(div_dividend), .div_divisor(div_divisor),
        .mul_a(mul_a), .mul_b(mul_b),
        .tk_below_first(tk_below_first), .tk_in_segment(tk_in_segment),
        .at_last_segment(at_last_segment)
    );

    restoring_divider u_divider (
        .clk(clk), .reset(reset), .start(div_start),
        .dividend(div_dividend), .divisor(div_divisor),
        .quotient(div_quotient), .done(div_done)
    );

    booth_multiplier u_multiplier (
        .clk(clk), .reset(reset), .start(mul_start),
        .a(mul_a), .b(mul_b),
        .product(mul_product), .done(mul_done)
    );

endmodule

/* rtl/interp_fsm.sv */
`timescale 1ns/1ps

module interp_fsm (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     cmd_valid,
    input  interp_ctrl_pkg::opcode_e cmd_op,
    input  logic                     res_ready,
    input  logic                     tk_below_first,
    input  logic                     tk_in_segment,
    input  logic                     at_last_segment,
    input  logic                     div_done,
    input  logic                     mul_done,
    output logic                     cmd_ready,
    output logic                     res_valid,
    output logic                     ram_we,
    output logic                     load_count,
    output logic                     load_lo,
    output logic                     load_hi,
    output logic                     advance,
    output logic                     load_frac,
    output logic                     load_result,
    output logic                     addr_sel,
    output logic                     res_sel,
    output logic                     div_start,
    output logic                     mul_start
);

    interp_ctrl_pkg::state_e state;
    interp_ctrl_pkg::state_e state_nxt;
    interp_ctrl_pkg::state_e after_result;
    interp_ctrl_pkg::opcode_e op;
    logic rd_wait;

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= interp_ctrl_pkg::ST_IDLE;
            rd_wait   <= 1'b0;
            div_start <= 1'b0;
            mul_start <= 1'b0;
        end else begin
            state <= state_nxt;
            // second cycle of a read sees the RAM data
            rd_wait <= (state == interp_ctrl_pkg::ST_RD_COUNT
                        || state == interp_ctrl_pkg::ST_RD_PAIR) && !rd_wait;
            div_start <= (state == interp_ctrl_pkg::ST_CMP) && tk_in_segment;
            // fraction register is loaded by the time this is seen
            mul_start <= (state == interp_ctrl_pkg::ST_DIV) && div_done;
        end
    end

    always_ff @(posedge clk) begin
        if (cmd_valid && cmd_ready) begin
            op <= cmd_op;
        end
    end

    assign after_result = (op == interp_ctrl_pkg::OP_INTERP_STORE) ? interp_ctrl_pkg::ST_WRITE
                                                                   : interp_ctrl_pkg::ST_RESULT;

    always_comb begin
        state_nxt   = state;
        cmd_ready   = 1'b0;
        res_valid   = 1'b0;
        ram_we      = 1'b0;
        load_count  = 1'b0;
        load_lo     = 1'b0;
        load_hi     = 1'b0;
        advance     = 1'b0;
        load_frac   = 1'b0;
        load_result = 1'b0;
        addr_sel    = 1'b0;
        res_sel     = 1'b0;
        case (state)
            interp_ctrl_pkg::ST_IDLE: begin
                cmd_ready = 1'b1;
                if (cmd_valid) begin
                    state_nxt = interp_ctrl_pkg::ST_RD_COUNT;
                end
            end
            interp_ctrl_pkg::ST_RD_COUNT: begin
                addr_sel = 1'b1;
                if (rd_wait) begin
                    load_count = 1'b1;
                    state_nxt  = interp_ctrl_pkg::ST_RD_PAIR;
                end
            end
            interp_ctrl_pkg::ST_RD_PAIR: begin
                if (rd_wait) begin
                    load_hi   = 1'b1;
                    state_nxt = interp_ctrl_pkg::ST_CMP;
                end
            end
            interp_ctrl_pkg::ST_CMP: begin
                if (tk_in_segment) begin
                    state_nxt = interp_ctrl_pkg::ST_DIV;
                end else if (tk_below_first || at_last_segment) begin
                    // outside the table, clamp to the end point
                    res_sel     = 1'b1;
                    load_result = 1'b1;
                    state_nxt   = after_result;
                end else begin
                    load_lo   = 1'b1;
                    advance   = 1'b1;
                    state_nxt = interp_ctrl_pkg::ST_RD_PAIR;
                end
            end
            interp_ctrl_pkg::ST_DIV: begin
                if (div_done) begin
                    load_frac = 1'b1;
                    state_nxt = interp_ctrl_pkg::ST_MUL;
                end
            end
            interp_ctrl_pkg::ST_MUL: begin
                if (mul_done) begin
                    state_nxt = interp_ctrl_pkg::ST_SUM;
                end
            end
            interp_ctrl_pkg::ST_SUM: begin
                load_result = 1'b1;
                state_nxt   = after_result;
            end
            interp_ctrl_pkg::ST_WRITE: begin
                ram_we    = 1'b1;
                addr_sel  = 1'b1;
                state_nxt = interp_ctrl_pkg::ST_RESULT;
            end
            interp_ctrl_pkg::ST_RESULT: begin
                res_valid = 1'b1;
                if (res_ready) begin
                    state_nxt = interp_ctrl_pkg::ST_IDLE;
                end
            end
            default: begin
                state_nxt = interp_ctrl_pkg::ST_IDLE;
            end
        endcase
    end

endmodule

/* rtl/interp_datapath.sv */
`timescale 1ns/1ps
`include "interp_settings.svh"

module interp_datapath (
    input  logic                                    clk,
    input  logic                                    reset,
    input  interp_data_pkg::word_t                  cmd_tk,
    input  interp_data_pkg::addr_t                  cmd_dest,
    input  logic                                    load_cmd,
    input  logic                                    load_count,
    input  logic                                    load_lo,
    input  logic                                    load_hi,
    input  logic                                    advance,
    input  logic                                    load_frac,
    input  logic                                    load_result,
    input  logic                                    addr_sel,
    input  logic                                    res_sel,
    input  interp_data_pkg::word_t                  ram_data1,
    input  interp_data_pkg::word_t                  ram_data2,
    input  interp_data_pkg::word_t                  div_quotient,
    input  interp_data_pkg::prod_t                  mul_product,
    output interp_data_pkg::addr_t                  ram_addr1,
    output interp_data_pkg::addr_t                  ram_addr2,
    output interp_data_pkg::word_t                  ram_wdata,
    output interp_data_pkg::word_t                  res_value,
    output logic                                    res_overflow,
    output logic [`INTERP_WORD_W+`INTERP_FRAC-1:0]  div_dividend,
    output interp_data_pkg::word_t                  div_divisor,
    output interp_data_pkg::word_t                  mul_a,
    output interp_data_pkg::word_t                  mul_b,
    output logic                                    tk_below_first,
    output logic                                    tk_in_segment,
    output logic                                    at_last_segment
);

    interp_data_pkg::word_t tk, tn, un, tz, uz, frac, result;
    interp_data_pkg::addr_t dest, count, idx;
    interp_data_pkg::word_t diff_tk, diff_u, scaled, sum;
    logic prod_fits;
    logic sum_ovf;

    always_ff @(posedge clk) begin
        if (reset) begin
            idx   <= '0;
            count <= '0;
        end else begin
            if (load_cmd) begin
                idx <= '0;
            end else if (advance) begin
                idx <= idx + 1'b1;
            end
            if (load_count) begin
                count <= ram_data1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load_cmd) begin
            tk   <= cmd_tk;
            dest <= cmd_dest;
        end
        // upper point slides down to the lower pair
        if (load_lo) begin
            tn <= tz;
            un <= uz;
        end
        if (load_hi) begin
            tz <= ram_data1;
            uz <= ram_data2;
        end
        if (load_frac) begin
            frac <= div_quotient;
        end
        if (load_result) begin
            result       <= res_sel ? uz : sum;
            res_overflow <= res_sel ? 1'b0 : (~prod_fits | sum_ovf);
        end
    end

    assign ram_addr1 = addr_sel ? interp_data_pkg::addr_t'(`INTERP_COUNT_ADDR)
                                : interp_data_pkg::addr_t'(`INTERP_T_BASE) + idx;
    assign ram_addr2 = addr_sel ? dest
                                : interp_data_pkg::addr_t'(`INTERP_U_BASE) + idx;

    // upper point is t[idx], earlier compares already passed tn
    assign tk_below_first  = (tk < tz) && (idx == '0);
    assign tk_in_segment   = (tk < tz) && (idx != '0);
    assign at_last_segment = (idx + 1'b1) >= count;

    assign diff_tk = tk - tn;
    assign diff_u  = uz - un;
    assign div_dividend = {diff_tk, {`INTERP_FRAC{1'b0}}};
    assign div_divisor  = tz - tn;
    assign mul_a = frac;
    assign mul_b = diff_u;

    // drop the fraction bits of the product
    assign scaled = mul_product[`INTERP_WORD_W+`INTERP_FRAC-1:`INTERP_FRAC];
    assign prod_fits = &mul_product[2*`INTERP_WORD_W-1:`INTERP_WORD_W+`INTERP_FRAC-1]
                     | ~|mul_product[2*`INTERP_WORD_W-1:`INTERP_WORD_W+`INTERP_FRAC-1];
    assign sum = un + scaled;
    assign sum_ovf = (un[`INTERP_WORD_W-1] == scaled[`INTERP_WORD_W-1])
                   && (sum[`INTERP_WORD_W-1] != un[`INTERP_WORD_W-1]);

    assign ram_wdata = result;
    assign res_value = result;

endmodule

/* rtl/restoring_divider.sv */
`timescale 1ns/1ps
`include "interp_settings.svh"

module restoring_divider (
    input  logic                                    clk,
    input  logic                                    reset,
    input  logic                                    start,
    input  logic [`INTERP_WORD_W+`INTERP_FRAC-1:0]  dividend,
    input  interp_data_pkg::word_t                  divisor,
    output interp_data_pkg::word_t                  quotient,
    output logic                                    done
);

    logic [`INTERP_WORD_W-1:0] rem;
    logic [`INTERP_WORD_W-1:0] rem_in;
    logic [`INTERP_WORD_W+`INTERP_FRAC-1:0] quo;
    logic [`INTERP_WORD_W+`INTERP_FRAC-1:0] quo_in;
    logic [`INTERP_WORD_W-1:0] dvsr;
    logic [`INTERP_WORD_W-1:0] dvsr_in;
    logic [`INTERP_WORD_W:0] part;
    logic [`INTERP_WORD_W:0] diff;
    logic [$clog2(`INTERP_WORD_W+`INTERP_FRAC)-1:0] count;
    logic busy;

    // divisor is a positive span, taken as unsigned
    assign rem_in  = start ? '0 : rem;
    assign quo_in  = start ? dividend : quo;
    assign dvsr_in = start ? divisor : dvsr;

    // bring down the next dividend bit
    assign part = {rem_in, quo_in[`INTERP_WORD_W+`INTERP_FRAC-1]};
    assign diff = part - {1'b0, dvsr_in};

    always_ff @(posedge clk) begin
        if (start || busy) begin
            dvsr <= dvsr_in;
            quo  <= {quo_in[`INTERP_WORD_W+`INTERP_FRAC-2:0], ~diff[`INTERP_WORD_W]};
            // borrow means restore the partial remainder
            rem  <= diff[`INTERP_WORD_W] ? part[`INTERP_WORD_W-1:0]
                                         : diff[`INTERP_WORD_W-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            busy  <= 1'b0;
            done  <= 1'b0;
            count <= '0;
        end else begin
            done <= 1'b0;
            if (start) begin
                busy  <= 1'b1;
                count <= 1'b1;
            end else if (busy) begin
                count <= count + 1'b1;
                if (count == `INTERP_WORD_W + `INTERP_FRAC - 1) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

    // fraction is below one, upper bits drop
    assign quotient = quo[`INTERP_WORD_W-1:0];

endmodule

/* rtl/booth_multiplier.sv */
`timescale 1ns/1ps
`include "interp_settings.svh"

module booth_multiplier (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   start,
    input  interp_data_pkg::word_t a,
    input  interp_data_pkg::word_t b,
    output interp_data_pkg::prod_t product,
    output logic                   done
);

    // {partial product with guard bit, multiplier, booth tail bit}
    logic [2*`INTERP_WORD_W+1:0] acc;
    logic [2*`INTERP_WORD_W+1:0] acc_in;
    logic [`INTERP_WORD_W:0] hi;
    logic [`INTERP_WORD_W:0] hi_next;
    interp_data_pkg::word_t mcand;
    interp_data_pkg::word_t mcand_in;
    logic [$clog2(`INTERP_WORD_W)-1:0] count;
    logic busy;

    // first step runs on the start edge
    assign acc_in = start ? {{(`INTERP_WORD_W+1){1'b0}}, b, 1'b0} : acc;
    assign mcand_in = start ? a : mcand;
    assign hi = acc_in[2*`INTERP_WORD_W+1:`INTERP_WORD_W+1];

    always_comb begin
        case (acc_in[1:0])
            2'b01: hi_next = hi + {mcand_in[`INTERP_WORD_W-1], mcand_in};
            2'b10: hi_next = hi - {mcand_in[`INTERP_WORD_W-1], mcand_in};
            default: hi_next = hi;
        endcase
    end

    always_ff @(posedge clk) begin
        if (start || busy) begin
            mcand <= mcand_in;
            // arithmetic shift right by one
            acc <= {hi_next[`INTERP_WORD_W], hi_next, acc_in[`INTERP_WORD_W:1]};
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            busy  <= 1'b0;
            done  <= 1'b0;
            count <= '0;
        end else begin
            done <= 1'b0;
            if (start) begin
                busy  <= 1'b1;
                count <= 1'b1;
            end else if (busy) begin
                count <= count + 1'b1;
                if (count == `INTERP_WORD_W - 1) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

    assign product = acc[2*`INTERP_WORD_W:1];

endmodule

/* rtl/interp_data_pkg.sv */
`include "interp_settings.svh"

package interp_data_pkg;

    // one fixed-point sample
    typedef logic signed [`INTERP_WORD_W-1:0] word_t;

    typedef logic [`INTERP_ADDR_W-1:0] addr_t;

    // full product, fraction bits doubled
    typedef logic signed [2*`INTERP_WORD_W-1:0] prod_t;

endpackage

/* rtl/interp_ctrl_pkg.sv */
package interp_ctrl_pkg;

    typedef enum logic [3:0] {
        ST_IDLE,
        ST_RD_COUNT,
        ST_RD_PAIR,
        ST_CMP,
        ST_DIV,
        ST_MUL,
        ST_SUM,
        ST_WRITE,
        ST_RESULT
    } state_e;

    // store variant also writes the result back to the RAM
    typedef enum logic {
        OP_INTERP       = 1'b0,
        OP_INTERP_STORE = 1'b1
    } opcode_e;

endpackage

/* rtl/interp_settings.svh */
`ifndef INTERP_SETTINGS_SVH
`define INTERP_SETTINGS_SVH

// signed fixed point, 7 fraction bits
`define INTERP_WORD_W 16
`define INTERP_FRAC 7

`define INTERP_ADDR_W 16

// table layout in the RAM
// word 0 holds the number of breakpoints
`define INTERP_COUNT_ADDR 0
`define INTERP_T_BASE 1
`define INTERP_U_BASE 512

`endif
